// File: Bender.yml
package:
  name: rename_pipe

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rename_pkg.sv
      - hdl/instr_decode.sv
      - hdl/re_name.sv
      - hdl/phys_regfile.sv
      - hdl/alu_execute.sv
      - hdl/rename_pipe_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/rename_pipe_sva.sv
      - verif/rename_pipe_tb.sv

// File: hdl/alu_execute.sv
// Single-stage execute with writeback register
// issue_ack is combinational, valid AND not stall
// The one pending writeback is forwarded to both sources
`timescale 1ns/1ns
`include "rename_settings.svh"

module alu_execute (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    instr_valid_i,
    input  logic                    stall_i,
    input  logic                    flush_unissued_i,
    output logic                    issue_ack_o,
    input  logic [`PHYS_ADDR_W-1:0] prs1_i,
    input  logic [`PHYS_ADDR_W-1:0] prs2_i,
    input  logic [`PHYS_ADDR_W-1:0] prd_i,
    input  logic [`XLEN-1:0]        op_a_i,
    input  logic [`XLEN-1:0]        op_b_i,
    input  logic [2:0]              alu_op_i,
    input  logic                    use_imm_i,
    input  logic [`XLEN-1:0]        imm_i,
    input  logic                    rd_write_i,
    output logic                    wb_valid_o,
    output logic [`PHYS_ADDR_W-1:0] wb_rd_o,
    output logic [`XLEN-1:0]        wb_data_o
);

    logic                    issue_ack;
    logic                    wb_valid_d;
    logic                    wb_valid_q;
    logic [`PHYS_ADDR_W-1:0] wb_rd_q;
    logic [`XLEN-1:0]        wb_data_q;

    logic                    fwd_a;
    logic                    fwd_b;
    logic [`XLEN-1:0]        opnd_a;
    logic [`XLEN-1:0]        reg_b;
    logic [`XLEN-1:0]        opnd_b;
    logic [`XLEN-1:0]        result;

    // Accept handshake
    assign issue_ack   = instr_valid_i & ~stall_i;
    assign issue_ack_o = issue_ack;

    // ------------------------------------------------------------------------
    // Operand forwarding
    // ------------------------------------------------------------------------
    // File is written only at the end of the wb cycle
    assign fwd_a  = wb_valid_q && (wb_rd_q == prs1_i);
    assign fwd_b  = wb_valid_q && (wb_rd_q == prs2_i);
    assign opnd_a = fwd_a ? wb_data_q : op_a_i;
    assign reg_b  = fwd_b ? wb_data_q : op_b_i;

    // I-type replaces the second source
    assign opnd_b = use_imm_i ? imm_i : reg_b;

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    always_comb begin
        case (alu_op_i)
            rename_pkg::ALU_ADD: result = opnd_a + opnd_b;
            rename_pkg::ALU_SUB: result = opnd_a - opnd_b;
            rename_pkg::ALU_XOR: result = opnd_a ^ opnd_b;
            rename_pkg::ALU_OR:  result = opnd_a | opnd_b;
            rename_pkg::ALU_AND: result = opnd_a & opnd_b;
            default:             result = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Writeback register
    // ------------------------------------------------------------------------
    // Cancelled or non-writing instructions leave no strobe
    assign wb_valid_d = issue_ack & rd_write_i & ~flush_unissued_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= wb_valid_d;
        end
    end

    // Payload holds the last real write
    always_ff @(posedge clk_i) begin
        if (wb_valid_d) begin
            wb_rd_q   <= prd_i;
            wb_data_q <= result;
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_rd_o    = wb_rd_q;
    assign wb_data_o  = wb_data_q;

endmodule

// File: hdl/instr_decode.sv
// Combinational decoder for ADD/SUB/XOR/OR/AND and ADDI/XORI/ORI/ANDI
// Everything else, including the shifts and compares, decodes to a no-op
// A no-op and any write to x0 give rd 0 with rd_write low
`timescale 1ns/1ns
`include "rename_settings.svh"

module instr_decode (
    input  rename_pkg::instr_t      instr_i,
    output logic [`ARCH_ADDR_W-1:0] rs1_o,
    output logic [`ARCH_ADDR_W-1:0] rs2_o,
    output logic [`ARCH_ADDR_W-1:0] rd_o,
    output logic [2:0]              alu_op_o,
    output logic                    use_imm_o,
    output logic [`XLEN-1:0]        imm_o,
    output logic                    rd_write_o
);

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic supported;

    // ------------------------------------------------------------------------
    // Format select and operation
    // ------------------------------------------------------------------------
    always_comb begin
        supported = 1'b0;
        alu_op_o  = rename_pkg::ALU_ADD;
        use_imm_o = 1'b0;
        rs1_o     = '0;
        rs2_o     = '0;

        // Opcode sits in the same bits in both views
        case (instr_i.rtype.opcode)
            OPC_OP: begin
                rs1_o = instr_i.rtype.rs1;
                rs2_o = instr_i.rtype.rs2;
                case (instr_i.rtype.funct3)
                    3'b000: begin
                        supported = 1'b1;
                        // funct7 bit 5 picks SUB over ADD
                        alu_op_o  = instr_i.rtype.funct7[5] ? rename_pkg::ALU_SUB
                                                            : rename_pkg::ALU_ADD;
                    end
                    3'b100: begin
                        supported = 1'b1;
                        alu_op_o  = rename_pkg::ALU_XOR;
                    end
                    3'b110: begin
                        supported = 1'b1;
                        alu_op_o  = rename_pkg::ALU_OR;
                    end
                    3'b111: begin
                        supported = 1'b1;
                        alu_op_o  = rename_pkg::ALU_AND;
                    end
                    default: supported = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                use_imm_o = 1'b1;
                // No second source for I-type
                rs1_o     = instr_i.itype.rs1;
                case (instr_i.itype.funct3)
                    3'b000: begin
                        supported = 1'b1;
                        alu_op_o  = rename_pkg::ALU_ADD;
                    end
                    3'b100: begin
                        supported = 1'b1;
                        alu_op_o  = rename_pkg::ALU_XOR;
                    end
                    3'b110: begin
                        supported = 1'b1;
                        alu_op_o  = rename_pkg::ALU_OR;
                    end
                    3'b111: begin
                        supported = 1'b1;
                        alu_op_o  = rename_pkg::ALU_AND;
                    end
                    default: supported = 1'b0;
                endcase
            end
            default: supported = 1'b0;
        endcase
    end

    // Writes to x0 are dropped here, so rename never sees them
    assign rd_write_o = supported && (instr_i.itype.rd != '0);
    assign rd_o       = rd_write_o ? instr_i.itype.rd : '0;

    // Sign-extended I immediate
    assign imm_o = {{(`XLEN-12){instr_i.itype.imm[11]}}, instr_i.itype.imm};

endmodule

// File: hdl/phys_regfile.sv
// Physical register file, two banks of the architectural set
// Reads are combinational, the write lands at the clock edge
// Address 0 is hard-wired to zero
`timescale 1ns/1ns
`include "rename_settings.svh"

module phys_regfile (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic [`PHYS_ADDR_W-1:0] raddr_a_i,
    input  logic [`PHYS_ADDR_W-1:0] raddr_b_i,
    output logic [`XLEN-1:0]        rdata_a_o,
    output logic [`XLEN-1:0]        rdata_b_o,
    input  logic                    we_i,
    input  logic [`PHYS_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]        wdata_i
);

    localparam int unsigned NR_WORDS = 1 << `PHYS_ADDR_W;

    logic [`XLEN-1:0] mem_q [0:NR_WORDS-1];

    // ------------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            // All words start at zero
            for (int unsigned i = 0; i < NR_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // ------------------------------------------------------------------------
    // Read ports
    // ------------------------------------------------------------------------
    // Same-cycle write is not visible, execute forwards it instead
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

endmodule

// File: hdl/re_name.sv
// Name-bit table, one bit per architectural register
// Values left under bank-1 names after a flush are not recovered
// x0 is never renamed and always maps to physical address 0
`timescale 1ns/1ns
`include "rename_settings.svh"

module re_name (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    flush_unissued_i,
    input  logic                    issue_ack_i,
    input  logic [`ARCH_ADDR_W-1:0] rs1_i,
    input  logic [`ARCH_ADDR_W-1:0] rs2_i,
    input  logic [`ARCH_ADDR_W-1:0] rd_i,
    output logic [`PHYS_ADDR_W-1:0] rs1_o,
    output logic [`PHYS_ADDR_W-1:0] rs2_o,
    output logic [`PHYS_ADDR_W-1:0] rd_o
);

    // Current name bit of every architectural register
    logic [`NR_ARCH_REGS-1:0] name_q;
    logic [`NR_ARCH_REGS-1:0] name_d;

    logic name_rs1;
    logic name_rs2;
    logic name_rd;
    logic rd_named;

    // ------------------------------------------------------------------------
    // Address mapping
    // ------------------------------------------------------------------------
    // x0 keeps its name
    assign rd_named = (rd_i != '0);

    // Sources read the live name
    assign name_rs1 = name_q[rs1_i] & `ENABLE_RENAME;
    assign name_rs2 = name_q[rs2_i] & `ENABLE_RENAME;

    // Destination takes the name it will hold after this write
    assign name_rd  = (name_q[rd_i] ^ rd_named) & `ENABLE_RENAME;

    assign rs1_o = {name_rs1, rs1_i};
    assign rs2_o = {name_rs2, rs2_i};
    assign rd_o  = {name_rd, rd_i};

    // ------------------------------------------------------------------------
    // Table update
    // ------------------------------------------------------------------------
    always_comb begin
        name_d = name_q;

        // Toggle on accept unless cancelled
        if (issue_ack_i && !flush_unissued_i && rd_named) begin
            name_d[rd_i] = ~name_q[rd_i];
        end

        // Entry 0 pinned low
        name_d[0] = 1'b0;

        // Full flush wins over any toggle
        if (flush_i) begin
            name_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            name_q <= '0;
        end else begin
            name_q <= name_d;
        end
    end

endmodule

// File: hdl/rename_pipe_top.sv
// Rename pipeline slice: decode, rename, register file, execute
// Hold instr_i stable until issue_ack_o is seen at a rising edge
// wb_valid_o follows an accepted write by exactly one cycle
`timescale 1ns/1ns
`include "rename_settings.svh"

module rename_pipe_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  rename_pkg::instr_t      instr_i,
    input  logic                    instr_valid_i,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  logic                    flush_unissued_i,
    output logic                    issue_ack_o,
    output logic                    wb_valid_o,
    output logic [`PHYS_ADDR_W-1:0] wb_rd_o,
    output logic [`XLEN-1:0]        wb_data_o
);

    // Decode to rename
    logic [`ARCH_ADDR_W-1:0] arch_rs1;
    logic [`ARCH_ADDR_W-1:0] arch_rs2;
    logic [`ARCH_ADDR_W-1:0] arch_rd;

    // Operation fields, decode to execute
    logic [2:0]              alu_op;
    logic                    use_imm;
    logic [`XLEN-1:0]        imm;
    logic                    rd_write;

    // Renamed addresses
    logic [`PHYS_ADDR_W-1:0] phys_rs1;
    logic [`PHYS_ADDR_W-1:0] phys_rs2;
    logic [`PHYS_ADDR_W-1:0] phys_rd;

    // Register file read data
    logic [`XLEN-1:0]        op_a;
    logic [`XLEN-1:0]        op_b;

    instr_decode i_instr_decode (
        .instr_i    (instr_i),
        .rs1_o      (arch_rs1),
        .rs2_o      (arch_rs2),
        .rd_o       (arch_rd),
        .alu_op_o   (alu_op),
        .use_imm_o  (use_imm),
        .imm_o      (imm),
        .rd_write_o (rd_write)
    );

    re_name i_re_name (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .flush_unissued_i (flush_unissued_i),
        .issue_ack_i      (issue_ack_o),
        .rs1_i            (arch_rs1),
        .rs2_i            (arch_rs2),
        .rd_i             (arch_rd),
        .rs1_o            (phys_rs1),
        .rs2_o            (phys_rs2),
        .rd_o             (phys_rd)
    );

    // Write port fed by the registered writeback
    phys_regfile i_phys_regfile (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (phys_rs1),
        .raddr_b_i (phys_rs2),
        .rdata_a_o (op_a),
        .rdata_b_o (op_b),
        .we_i      (wb_valid_o),
        .waddr_i   (wb_rd_o),
        .wdata_i   (wb_data_o)
    );

    alu_execute i_alu_execute (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .instr_valid_i    (instr_valid_i),
        .stall_i          (stall_i),
        .flush_unissued_i (flush_unissued_i),
        .issue_ack_o      (issue_ack_o),
        .prs1_i           (phys_rs1),
        .prs2_i           (phys_rs2),
        .prd_i            (phys_rd),
        .op_a_i           (op_a),
        .op_b_i           (op_b),
        .alu_op_i         (alu_op),
        .use_imm_i        (use_imm),
        .imm_i            (imm),
        .rd_write_i       (rd_write),
        .wb_valid_o       (wb_valid_o),
        .wb_rd_o          (wb_rd_o),
        .wb_data_o        (wb_data_o)
    );

endmodule

// File: hdl/rename_pkg.sv
// Instruction word views and ALU operation codes for the rename slice
// Only the R-type and I-type layouts of RV32I are described
`include "rename_settings.svh"

package rename_pkg;

    // One 32-bit word, decoded either as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [6:0]              funct7;
            logic [`ARCH_ADDR_W-1:0] rs2;
            logic [`ARCH_ADDR_W-1:0] rs1;
            logic [2:0]              funct3;
            logic [`ARCH_ADDR_W-1:0] rd;
            logic [6:0]              opcode;
        } rtype;
        struct packed {
            logic [11:0]             imm;
            logic [`ARCH_ADDR_W-1:0] rs1;
            logic [2:0]              funct3;
            logic [`ARCH_ADDR_W-1:0] rd;
            logic [6:0]              opcode;
        } itype;
    } instr_t;

    // ALU operation codes, decoder to execute
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_XOR = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_AND = 3'd4;

endpackage

// File: hdl/rename_settings.svh
// Sizes and switches shared by the rename pipeline slice
// PHYS_ADDR_W must stay one bit wider than ARCH_ADDR_W
// The extra top bit of a physical address is the name bit
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// Renaming switch, 0 keeps every register in bank 0
`define ENABLE_RENAME 1'b1

// Architectural register set, one name bit each
`define NR_ARCH_REGS 32
`define ARCH_ADDR_W 5

// Two banks of architectural registers in the physical file
`define PHYS_ADDR_W 6

// Datapath width
`define XLEN 32

`endif

// File: sources.f
+incdir+hdl
hdl/rename_pkg.sv
hdl/instr_decode.sv
hdl/re_name.sv
hdl/phys_regfile.sv
hdl/alu_execute.sv
hdl/rename_pipe_top.sv
verif/rename_pipe_sva.sv
verif/rename_pipe_tb.sv

// File: verif/rename_pipe_sva.sv
// Assertions bound into every alu_execute instance
// wb_rd_o is only looked at while wb_valid_o is high
`timescale 1ns/1ns
`include "rename_settings.svh"

module rename_pipe_sva (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    issue_ack_o,
    input logic                    stall_i,
    input logic                    wb_valid_o,
    input logic [`PHYS_ADDR_W-1:0] wb_rd_o
);

    // Bank-1 name of x0
    localparam logic [`PHYS_ADDR_W-1:0] X0_BANK1 = 1 << (`PHYS_ADDR_W - 1);

    // Number of failed assertions
    int unsigned fail_cnt = 0;

    // No strobe while held in reset
    a_wb_idle_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !wb_valid_o)
        else begin
            $error("wb_valid_o high while reset is active");
            fail_cnt++;
        end

    // Strobe only one cycle after an accept
    a_wb_after_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_valid_o |-> $past(issue_ack_o))
        else begin
            $error("wb_valid_o without an accept in the previous cycle");
            fail_cnt++;
        end

    // x0 is never renamed
    a_wb_not_x0: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_valid_o |-> (wb_rd_o != X0_BANK1))
        else begin
            $error("wb_rd_o points at a renamed x0");
            fail_cnt++;
        end

    // Back-pressure blocks the accept
    a_no_ack_on_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
        stall_i |-> !issue_ack_o)
        else begin
            $error("issue_ack_o high while stall_i is high");
            fail_cnt++;
        end

endmodule

bind alu_execute rename_pipe_sva i_rename_pipe_sva (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue_ack_o (issue_ack_o),
    .stall_i     (stall_i),
    .wb_valid_o  (wb_valid_o),
    .wb_rd_o     (wb_rd_o)
);

// File: verif/rename_pipe_tb.sv
// Random-stimulus testbench for the rename pipeline slice
// Inputs change 2 ns after the rising edge
// Outputs are sampled mid-cycle
// The model keeps its own name table and physical file
`timescale 1ns/1ns
`include "rename_settings.svh"

module rename_pipe_tb;

    localparam int RESET_CYCLES = 16;
    localparam int N_DEP        = 300;
    localparam int N_X0         = 64;
    localparam int N_STALL      = 200;
    localparam int N_CANCEL     = 150;
    localparam int N_FLUSH      = 100;
    localparam int N_UNK        = 64;
    // Stalls roughly double the cycles per instruction
    localparam int STIM_CYCLES  = N_DEP + N_X0 + 2 * N_STALL + N_CANCEL
                                + N_FLUSH + `NR_ARCH_REGS + 2 * N_UNK + 16;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + RESET_CYCLES;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic                    clk;
    logic                    rst_n;
    rename_pkg::instr_t      instr;
    logic                    instr_valid;
    logic                    stall;
    logic                    flush;
    logic                    flush_unissued;
    logic                    issue_ack;
    logic                    wb_valid;
    logic [`PHYS_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]        wb_data;

    // Model state
    logic [`NR_ARCH_REGS-1:0] name_m;
    logic [`XLEN-1:0]         file_m [0:(1 << `PHYS_ADDR_W)-1];
    logic                     exp_wb_valid;
    logic [`PHYS_ADDR_W-1:0]  exp_wb_rd;
    logic [`XLEN-1:0]         exp_wb_data;

    logic [31:0] lfsr_q = 32'h85a2641c;
    int          cycle_cnt;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;
    int          sva_errors;

    rename_pipe_top dut (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .instr_i          (instr),
        .instr_valid_i    (instr_valid),
        .stall_i          (stall),
        .flush_i          (flush),
        .flush_unissued_i (flush_unissued),
        .issue_ack_o      (issue_ack),
        .wb_valid_o       (wb_valid),
        .wb_rd_o          (wb_rd),
        .wb_data_o        (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: stimulus still running after %0d cycles", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Random numbers and instruction words
    // ------------------------------------------------------------------------
    // Taps at bits 32, 22, 2 and 1
    // One step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int unsigned i = 0; i < n; i++) begin
            fb    = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r     = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic rename_pkg::instr_t make_instr(input logic [4:0] rd,
                                                      input logic [4:0] rs1,
                                                      input logic [4:0] rs2);
        rename_pkg::instr_t w;
        logic [1:0]         sel;
        logic [2:0]         f3;
        w   = '0;
        sel = rand_bits(2);
        f3  = (sel == 2'd0) ? 3'b000 : (sel == 2'd1) ? 3'b100 :
              (sel == 2'd2) ? 3'b110 : 3'b111;
        if (rand_bits(1)) begin
            w.rtype.opcode = OPC_OP;
            w.rtype.rd     = rd;
            w.rtype.funct3 = f3;
            w.rtype.rs1    = rs1;
            w.rtype.rs2    = rs2;
            // SUB shares funct3 000 with ADD
            w.rtype.funct7 = (f3 == 3'b000 && rand_bits(1)) ? 7'h20 : 7'h00;
        end else begin
            w.itype.opcode = OPC_OP_IMM;
            w.itype.rd     = rd;
            w.itype.funct3 = f3;
            w.itype.rs1    = rs1;
            w.itype.imm    = rand_bits(12);
        end
        return w;
    endfunction

    // Any word whose opcode is neither OP nor OP-IMM
    function automatic rename_pkg::instr_t make_unknown();
        rename_pkg::instr_t w;
        w = rand_bits(32);
        if (w.rtype.opcode == OPC_OP || w.rtype.opcode == OPC_OP_IMM) begin
            w.rtype.opcode[2] = ~w.rtype.opcode[2];
        end
        return w;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    task automatic model_accept(input rename_pkg::instr_t w, input logic cancel);
        logic [6:0]              opc;
        logic [2:0]              f3;
        logic [4:0]              rd;
        logic                    ok;
        logic [`XLEN-1:0]        a;
        logic [`XLEN-1:0]        b;
        logic [`XLEN-1:0]        res;
        logic [`PHYS_ADDR_W-1:0] prd;
        opc = w.rtype.opcode;
        f3  = w.rtype.funct3;
        rd  = w.rtype.rd;
        ok  = (opc == OPC_OP || opc == OPC_OP_IMM) &&
              (f3 == 3'b000 || f3 == 3'b100 || f3 == 3'b110 || f3 == 3'b111);
        // Sources use the live name
        // x0 reads the zero word
        a = file_m[{name_m[w.rtype.rs1] & `ENABLE_RENAME, w.rtype.rs1}];
        if (opc == OPC_OP_IMM) begin
            b = {{(`XLEN-12){w.itype.imm[11]}}, w.itype.imm};
        end else begin
            b = file_m[{name_m[w.rtype.rs2] & `ENABLE_RENAME, w.rtype.rs2}];
        end
        case (f3)
            3'b000:  res = (opc == OPC_OP && w.rtype.funct7[5]) ? a - b : a + b;
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        exp_wb_valid = ok && (rd != 5'd0) && !cancel;
        if (exp_wb_valid) begin
            prd         = {~name_m[rd] & `ENABLE_RENAME, rd};
            exp_wb_rd   = prd;
            exp_wb_data = res;
            // Program order makes the file update immediate
            file_m[prd] = res;
            name_m[rd]  = ~name_m[rd];
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus and checks
    // ------------------------------------------------------------------------
    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED t=%0t %s expected %h got %h", $time, sig, exp, act);
        test_errors++;
    endtask

    // One clock of drive, mid-cycle sample and model step
    task automatic apply_cycle(input rename_pkg::instr_t w, input logic valid,
                               input logic stl, input logic fl, input logic fu,
                               output logic ack_seen);
        @(posedge clk);
        #2;
        instr          = w;
        instr_valid    = valid;
        stall          = stl;
        flush          = fl;
        flush_unissued = fu;
        #8;
        test_checks++;
        ack_seen = issue_ack;
        if (issue_ack !== (valid && !stl)) begin
            report_mismatch("issue_ack_o", valid && !stl, issue_ack);
        end
        if (wb_valid !== exp_wb_valid) begin
            report_mismatch("wb_valid_o", exp_wb_valid, wb_valid);
        end else if (exp_wb_valid) begin
            if (wb_rd !== exp_wb_rd) begin
                report_mismatch("wb_rd_o", exp_wb_rd, wb_rd);
            end
            if (wb_data !== exp_wb_data) begin
                report_mismatch("wb_data_o", exp_wb_data, wb_data);
            end
        end
        if (valid && !stl) begin
            model_accept(w, fu);
        end else begin
            exp_wb_valid = 1'b0;
        end
        // Full flush overrides any toggle at the same edge
        if (fl) begin
            name_m = '0;
        end
    endtask

    // Hold the word until the DUT acknowledges it
    task automatic issue(input rename_pkg::instr_t w, input logic stall_en,
                         input logic cancel_en, input logic fl);
        logic stl;
        logic fu;
        logic ack_seen;
        do begin
            stl = stall_en ? rand_bits(1) : 1'b0;
            fu  = cancel_en ? (rand_bits(2) == 2'd0) : 1'b0;
            apply_cycle(w, 1'b1, stl, fl, fu, ack_seen);
        end while (!ack_seen);
    endtask

    task automatic idle_cycle();
        logic ack_seen;
        apply_cycle('0, 1'b0, 1'b0, 1'b0, 1'b0, ack_seen);
    endtask

    task automatic finish_test(input string name);
        // Last writeback is checked in the drain cycle
        idle_cycle();
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        rst_n          = 1'b0;
        instr          = '0;
        instr_valid    = 1'b0;
        stall          = 1'b0;
        flush          = 1'b0;
        flush_unissued = 1'b0;
        name_m         = '0;
        exp_wb_valid   = 1'b0;
        exp_wb_rd      = '0;
        exp_wb_data    = '0;
        cycle_cnt      = 0;
        test_checks    = 0;
        test_errors    = 0;
        total_checks   = 0;
        total_errors   = 0;
        sva_errors     = 0;
        for (int i = 0; i < (1 << `PHYS_ADDR_W); i++) begin
            file_m[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Few registers so back-to-back dependences are common
        repeat (N_DEP) issue(make_instr(rand_bits(3), rand_bits(3), rand_bits(3)), 0, 0, 0);
        finish_test("test 1 dependent writes");

        repeat (N_X0) begin
            issue(make_instr(rand_bits(1) ? 5'd0 : rand_bits(3),
                             rand_bits(1) ? 5'd0 : rand_bits(3),
                             rand_bits(1) ? 5'd0 : rand_bits(3)), 0, 0, 0);
        end
        finish_test("test 2 x0 handling");

        repeat (N_STALL) issue(make_instr(rand_bits(3), rand_bits(3), rand_bits(3)), 1, 0, 0);
        finish_test("test 3 back-pressure");

        repeat (N_CANCEL) issue(make_instr(rand_bits(3), rand_bits(3), rand_bits(3)), 0, 1, 0);
        finish_test("test 4 cancelled instructions");

        // Idle flush followed by one write per register
        begin
            logic ack_seen;
            apply_cycle('0, 1'b0, 1'b0, 1'b1, 1'b0, ack_seen);
        end
        for (int r = 1; r < `NR_ARCH_REGS; r++) begin
            issue(make_instr(r, rand_bits(5), rand_bits(5)), 0, 0, 0);
        end
        repeat (N_FLUSH) begin
            issue(make_instr(rand_bits(3), rand_bits(3), rand_bits(3)), 0, 0,
                  rand_bits(4) == 4'd0);
        end
        finish_test("test 5 full flush");

        // Known writes after each no-op expose any stray toggle
        repeat (N_UNK) begin
            issue(make_unknown(), 0, 0, 0);
            issue(make_instr(rand_bits(3), rand_bits(3), rand_bits(3)), 0, 0, 0);
        end
        finish_test("test 6 unknown opcodes");

        sva_errors = dut.i_alu_execute.i_rename_pipe_sva.fail_cnt;
        $display("total: %0d checks, %0d errors, %0d assertion failures",
                 total_checks, total_errors, sva_errors);
        if (total_errors == 0 && sva_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
